// File: upscaler_config.svh
`ifndef UPSCALER_CONFIG_SVH
`define UPSCALER_CONFIG_SVH

// bits per colour component
`define UPS_COMPONENT_DEPTH 8

// bits of a pixel or line count
`define UPS_COORD_WIDTH 11

// pixels held per buffered line
`define UPS_LINE_BUFFER_SIZE 1024

// lines in the ring, also the vertical delay of the output
`define UPS_LINE_BUFFER_COUNT 3

// fraction bits of a scale step
`define UPS_DELTA_PRECISION 12

`endif

// File: upscaler_pkg.sv
`default_nettype none

`include "upscaler_config.svh"

package upscaler_pkg;

	typedef logic [`UPS_COMPONENT_DEPTH-1:0] component_t;
	typedef logic [`UPS_COORD_WIDTH-1:0] coord_t;
	typedef logic [1:0] line_idx_t;

	// fixed point, PRECISION fraction bits
	typedef logic [`UPS_DELTA_PRECISION:0] delta_t;
	typedef logic [`UPS_COORD_WIDTH+`UPS_DELTA_PRECISION-1:0] acc_t;

	typedef struct packed {
		component_t red;
		component_t green;
		component_t blue;
	} pixel_t;

	// syncs are active low
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic hblank;
		logic vblank;
	} video_timing_t;

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_BUSY,
		DIV_DONE
	} div_state_t;

endpackage

`default_nettype wire

// File: video_input_capture.sv
`default_nettype none

`include "upscaler_config.svh"

module video_input_capture (
	input wire i_ClkA,
	input wire i_rst_n,
	input wire upscaler_pkg::video_timing_t i_timing,
	input wire upscaler_pkg::pixel_t i_pixel,
	output logic o_wr_en,
	output upscaler_pkg::line_idx_t o_wr_line,
	output upscaler_pkg::coord_t o_wr_col,
	output upscaler_pkg::pixel_t o_wr_pixel,
	output upscaler_pkg::coord_t o_src_width,
	output upscaler_pkg::coord_t o_src_height,
	output upscaler_pkg::line_idx_t o_sof_line
);
	import upscaler_pkg::*;

	logic hblank_q;
	logic vblank_q;
	logic line_start;
	logic frame_start;
	logic line_active;
	coord_t h_count;
	coord_t v_count;
	line_idx_t line_idx;
	line_idx_t line_idx_next;

	// falling blank edges mark line and frame starts
	assign line_start = hblank_q & ~i_timing.hblank;
	assign frame_start = vblank_q & ~i_timing.vblank;
	assign line_active = ~i_timing.vblank;

	assign line_idx_next = (line_idx == line_idx_t'(`UPS_LINE_BUFFER_COUNT - 1)) ?
		'0 : line_idx + line_idx_t'(1);

	// first pixel of a line goes to column 0 of the next ring slot
	assign o_wr_en = ~i_timing.hblank & ~i_timing.vblank;
	assign o_wr_col = line_start ? '0 : h_count;
	assign o_wr_line = (line_start && line_active) ? line_idx_next : line_idx;
	assign o_wr_pixel = i_pixel;

	always_ff @(posedge i_ClkA or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hblank_q <= 1'b0;
			vblank_q <= 1'b0;
			h_count <= '0;
			v_count <= '0;
			line_idx <= '0;
			o_src_width <= '0;
			o_src_height <= '0;
			o_sof_line <= '0;
		end else begin
			hblank_q <= i_timing.hblank;
			vblank_q <= i_timing.vblank;

			// width of the line just finished
			if (line_start) begin
				o_src_width <= h_count;
				h_count <= coord_t'(1);
				if (line_active) begin
					line_idx <= line_idx_next;
				end
			end else if (!i_timing.hblank) begin
				h_count <= h_count + coord_t'(1);
			end

			// the first active line of the frame lands in line_idx_next
			if (frame_start) begin
				o_src_height <= v_count;
				o_sof_line <= line_idx_next;
				v_count <= line_start ? coord_t'(1) : '0;
			end else if (line_start && line_active) begin
				v_count <= v_count + coord_t'(1);
			end
		end
	end

endmodule

`default_nettype wire

// File: line_buffer_ram.sv
`default_nettype none

`include "upscaler_config.svh"

module line_buffer_ram (
	input wire i_ClkA,
	input wire i_wr_en,
	input wire upscaler_pkg::line_idx_t i_wr_line,
	input wire upscaler_pkg::coord_t i_wr_col,
	input wire upscaler_pkg::pixel_t i_wr_pixel,
	input wire i_ClkB,
	input wire upscaler_pkg::line_idx_t i_rd_line,
	input wire upscaler_pkg::coord_t i_rd_col,
	output upscaler_pkg::pixel_t o_rd_pixel
);
	import upscaler_pkg::*;

	localparam int unsigned COL_BITS = $clog2(`UPS_LINE_BUFFER_SIZE);

	// one packed pixel per entry, whole ring in one array
	pixel_t mem [`UPS_LINE_BUFFER_COUNT][`UPS_LINE_BUFFER_SIZE];

	// write side, domain A
	always_ff @(posedge i_ClkA) begin
		if (i_wr_en) begin
			mem[i_wr_line][i_wr_col[COL_BITS-1:0]] <= i_wr_pixel;
		end
	end

	// read side, domain B, one cycle latency
	always_ff @(posedge i_ClkB) begin
		o_rd_pixel <= mem[i_rd_line][i_rd_col[COL_BITS-1:0]];
	end

endmodule

`default_nettype wire

// File: scale_step_divider.sv
`default_nettype none

`include "upscaler_config.svh"

module scale_step_divider (
	input wire i_ClkB,
	input wire i_rst_n,
	input wire i_start,
	input wire upscaler_pkg::coord_t i_num,
	input wire upscaler_pkg::coord_t i_den,
	output upscaler_pkg::delta_t o_step,
	output logic o_done
);
	import upscaler_pkg::*;

	localparam int unsigned QBITS = `UPS_COORD_WIDTH + `UPS_DELTA_PRECISION;
	localparam int unsigned CBITS = $clog2(QBITS);

	div_state_t state;
	acc_t quot;
	coord_t divisor;
	coord_t rem;
	logic [`UPS_COORD_WIDTH:0] trial;
	logic [CBITS-1:0] bit_cnt;

	// shift in next dividend bit
	assign trial = {rem, quot[QBITS-1]};

	always_ff @(posedge i_ClkB or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= DIV_IDLE;
			quot <= '0;
			divisor <= '0;
			rem <= '0;
			bit_cnt <= '0;
			o_step <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			// zero denominator keeps the old step
			if (i_start && (i_den != '0)) begin
				quot <= acc_t'({i_num, {`UPS_DELTA_PRECISION{1'b0}}});
				divisor <= i_den;
				rem <= '0;
				bit_cnt <= CBITS'(QBITS - 1);
				state <= DIV_BUSY;
			end else begin
				case (state)
					DIV_BUSY: begin
						// one quotient bit per cycle, quotient bits replace dividend bits
						if (trial >= {1'b0, divisor}) begin
							rem <= coord_t'(trial - {1'b0, divisor});
							quot <= {quot[QBITS-2:0], 1'b1};
						end else begin
							rem <= coord_t'(trial);
							quot <= {quot[QBITS-2:0], 1'b0};
						end
						if (bit_cnt == '0) begin
							state <= DIV_DONE;
						end else begin
							bit_cnt <= bit_cnt - 1'b1;
						end
					end
					DIV_DONE: begin
						o_step <= quot[`UPS_DELTA_PRECISION:0];
						o_done <= 1'b1;
						state <= DIV_IDLE;
					end
					default: begin
						state <= DIV_IDLE;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: video_output_scaler.sv
`default_nettype none

`include "upscaler_config.svh"

module video_output_scaler (
	input wire i_ClkB,
	input wire i_rst_n,
	input wire upscaler_pkg::video_timing_t i_timing,
	input wire upscaler_pkg::coord_t i_src_width,
	input wire upscaler_pkg::coord_t i_src_height,
	input wire upscaler_pkg::line_idx_t i_sof_line,
	output logic o_hdiv_start,
	output upscaler_pkg::coord_t o_hdiv_num,
	output upscaler_pkg::coord_t o_hdiv_den,
	input wire upscaler_pkg::delta_t i_hstep,
	input wire i_hdiv_done,
	output logic o_vdiv_start,
	output upscaler_pkg::coord_t o_vdiv_num,
	output upscaler_pkg::coord_t o_vdiv_den,
	input wire upscaler_pkg::delta_t i_vstep,
	input wire i_vdiv_done,
	output upscaler_pkg::line_idx_t o_rd_line,
	output upscaler_pkg::coord_t o_rd_col,
	input wire upscaler_pkg::pixel_t i_rd_pixel,
	output upscaler_pkg::video_timing_t o_timing,
	output upscaler_pkg::pixel_t o_pixel,
	output logic o_locked
);
	import upscaler_pkg::*;

	localparam int unsigned DEPTH = `UPS_LINE_BUFFER_COUNT;
	localparam int unsigned PREC = `UPS_DELTA_PRECISION;
	localparam int unsigned CW = `UPS_COORD_WIDTH;

	logic hsync_q;
	logic hblank_q;
	logic hsync_fall;
	logic line_start;
	logic frame_start;
	logic h_active;
	logic v_active;
	logic [DEPTH-1:0] vsync_dly;
	logic [DEPTH-1:0] vblank_dly;
	coord_t h_count;
	coord_t v_count;
	coord_t out_width;
	coord_t out_height;
	coord_t src_width_b;
	coord_t src_height_b;
	line_idx_t sof_b;
	delta_t hstep_pend;
	delta_t vstep_pend;
	delta_t h_step;
	delta_t v_step;
	acc_t h_acc;
	acc_t v_acc;
	coord_t cur_row;
	coord_t rd_row;
	logic [CW:0] ring_sum;
	video_timing_t timing_q;
	logic active_q;

	assign hsync_fall = hsync_q & ~i_timing.hsync;
	assign line_start = hblank_q & ~i_timing.hblank;
	// delayed vblank falls on this hsync edge
	assign frame_start = hsync_fall & vblank_dly[DEPTH-1] & ~vblank_dly[DEPTH-2];
	assign h_active = ~i_timing.hblank;
	assign v_active = ~vblank_dly[DEPTH-1];

	// nearest source row and column
	assign rd_row = line_start ? v_acc[PREC +: CW] : cur_row;
	assign ring_sum = {1'b0, rd_row} + (CW + 1)'(sof_b);
	assign o_rd_line = line_idx_t'(ring_sum % DEPTH);
	assign o_rd_col = line_start ? '0 : h_acc[PREC +: CW];

	assign o_hdiv_num = src_width_b;
	assign o_hdiv_den = out_width;
	assign o_vdiv_num = src_height_b;
	assign o_vdiv_den = out_height;

	always_ff @(posedge i_ClkB or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hsync_q <= 1'b1;
			hblank_q <= 1'b0;
			vsync_dly <= '1;
			vblank_dly <= '0;
			h_count <= '0;
			v_count <= '0;
			out_width <= '0;
			out_height <= '0;
			src_width_b <= '0;
			src_height_b <= '0;
			sof_b <= '0;
			hstep_pend <= '0;
			vstep_pend <= '0;
			h_step <= '0;
			v_step <= '0;
			h_acc <= '0;
			v_acc <= '0;
			cur_row <= '0;
			o_hdiv_start <= 1'b0;
			o_vdiv_start <= 1'b0;
			o_locked <= 1'b0;
		end else begin
			hsync_q <= i_timing.hsync;
			hblank_q <= i_timing.hblank;

			// start one cycle late so the fresh size is the denominator
			o_hdiv_start <= line_start;
			o_vdiv_start <= frame_start;
			if (i_hdiv_done) begin
				hstep_pend <= i_hstep;
			end
			if (i_vdiv_done) begin
				vstep_pend <= i_vstep;
			end

			// vertical delay line, one stage per output line
			if (hsync_fall) begin
				vsync_dly <= {vsync_dly[DEPTH-2:0], i_timing.vsync};
				vblank_dly <= {vblank_dly[DEPTH-2:0], i_timing.vblank};
			end

			if (line_start) begin
				out_width <= h_count;
				h_count <= coord_t'(1);
				h_step <= hstep_pend;
				h_acc <= acc_t'(hstep_pend);
			end else if (h_active) begin
				h_count <= h_count + coord_t'(1);
				h_acc <= h_acc + acc_t'(h_step);
			end

			// source values are sampled once per output frame
			if (frame_start) begin
				out_height <= v_count;
				v_count <= '0;
				v_acc <= '0;
				v_step <= vstep_pend;
				src_width_b <= i_src_width;
				src_height_b <= i_src_height;
				sof_b <= i_sof_line;
				o_locked <= 1'b1;
			end else if (line_start && v_active) begin
				v_count <= v_count + coord_t'(1);
				cur_row <= v_acc[PREC +: CW];
				v_acc <= v_acc + acc_t'(v_step);
			end
		end
	end

	// output pipeline, aligned with the registered ram read
	always_ff @(posedge i_ClkB or negedge i_rst_n) begin
		if (!i_rst_n) begin
			timing_q <= '{hsync: 1'b1, vsync: 1'b1, hblank: 1'b0, vblank: 1'b0};
			active_q <= 1'b0;
			o_timing <= '{hsync: 1'b1, vsync: 1'b1, hblank: 1'b0, vblank: 1'b0};
			o_pixel <= '0;
		end else begin
			timing_q.hsync <= i_timing.hsync;
			timing_q.vsync <= vsync_dly[DEPTH-1];
			timing_q.hblank <= i_timing.hblank;
			timing_q.vblank <= vblank_dly[DEPTH-1];
			active_q <= h_active & v_active;
			o_timing <= timing_q;
			o_pixel <= active_q ? i_rd_pixel : '0;
		end
	end

endmodule

`default_nettype wire

// File: upscaler_top.sv
`default_nettype none

module upscaler_top (
	input wire i_ClkA,
	input wire i_ClkB,
	input wire i_rst_n,
	input wire upscaler_pkg::video_timing_t i_timing_a,
	input wire upscaler_pkg::pixel_t i_pixel_a,
	input wire upscaler_pkg::video_timing_t i_timing_b,
	output wire upscaler_pkg::video_timing_t o_timing_b,
	output wire upscaler_pkg::pixel_t o_pixel_b,
	output wire o_locked
);
	import upscaler_pkg::*;

	// write port, domain A
	logic wr_en;
	line_idx_t wr_line;
	coord_t wr_col;
	pixel_t wr_pixel;

	// quasi-static source measurements
	coord_t src_width;
	coord_t src_height;
	line_idx_t sof_line;

	// read port, domain B
	line_idx_t rd_line;
	coord_t rd_col;
	pixel_t rd_pixel;

	logic hdiv_start;
	coord_t hdiv_num;
	coord_t hdiv_den;
	delta_t hstep;
	logic hdiv_done;
	logic vdiv_start;
	coord_t vdiv_num;
	coord_t vdiv_den;
	delta_t vstep;
	logic vdiv_done;

	video_input_capture u_capture (
		.i_ClkA(i_ClkA),
		.i_rst_n(i_rst_n),
		.i_timing(i_timing_a),
		.i_pixel(i_pixel_a),
		.o_wr_en(wr_en),
		.o_wr_line(wr_line),
		.o_wr_col(wr_col),
		.o_wr_pixel(wr_pixel),
		.o_src_width(src_width),
		.o_src_height(src_height),
		.o_sof_line(sof_line)
	);

	line_buffer_ram u_ram (
		.i_ClkA(i_ClkA),
		.i_wr_en(wr_en),
		.i_wr_line(wr_line),
		.i_wr_col(wr_col),
		.i_wr_pixel(wr_pixel),
		.i_ClkB(i_ClkB),
		.i_rd_line(rd_line),
		.i_rd_col(rd_col),
		.o_rd_pixel(rd_pixel)
	);

	scale_step_divider u_hdiv (
		.i_ClkB(i_ClkB),
		.i_rst_n(i_rst_n),
		.i_start(hdiv_start),
		.i_num(hdiv_num),
		.i_den(hdiv_den),
		.o_step(hstep),
		.o_done(hdiv_done)
	);

	scale_step_divider u_vdiv (
		.i_ClkB(i_ClkB),
		.i_rst_n(i_rst_n),
		.i_start(vdiv_start),
		.i_num(vdiv_num),
		.i_den(vdiv_den),
		.o_step(vstep),
		.o_done(vdiv_done)
	);

	video_output_scaler u_scaler (
		.i_ClkB(i_ClkB),
		.i_rst_n(i_rst_n),
		.i_timing(i_timing_b),
		.i_src_width(src_width),
		.i_src_height(src_height),
		.i_sof_line(sof_line),
		.o_hdiv_start(hdiv_start),
		.o_hdiv_num(hdiv_num),
		.o_hdiv_den(hdiv_den),
		.i_hstep(hstep),
		.i_hdiv_done(hdiv_done),
		.o_vdiv_start(vdiv_start),
		.o_vdiv_num(vdiv_num),
		.o_vdiv_den(vdiv_den),
		.i_vstep(vstep),
		.i_vdiv_done(vdiv_done),
		.o_rd_line(rd_line),
		.o_rd_col(rd_col),
		.i_rd_pixel(rd_pixel),
		.o_timing(o_timing_b),
		.o_pixel(o_pixel_b),
		.o_locked(o_locked)
	);

endmodule

`default_nettype wire

// File: upscaler_assertions.sv
`default_nettype none

module upscaler_assertions (
	input wire i_ClkB,
	input wire i_rst_n,
	input wire upscaler_pkg::video_timing_t i_timing_b,
	input wire upscaler_pkg::video_timing_t o_timing_b,
	input wire upscaler_pkg::pixel_t o_pixel_b,
	input wire o_locked
);
	timeunit 1ns;
	timeprecision 1ps;
	import upscaler_pkg::*;

	// history depth after reset before the latency check applies
	logic [1:0] settle;

	// number of assertion failures so far
	int fail_count = 0;

	always_ff @(posedge i_ClkB or negedge i_rst_n) begin
		if (!i_rst_n) begin
			settle <= '0;
		end else if (settle != 2'd3) begin
			settle <= settle + 2'd1;
		end
	end

	property locked_sticky;
		@(posedge i_ClkB) disable iff (!i_rst_n)
		o_locked |=> o_locked;
	endproperty

	property blank_pixel_zero;
		@(posedge i_ClkB) disable iff (!i_rst_n)
		(o_timing_b.hblank || o_timing_b.vblank) |-> (o_pixel_b == '0);
	endproperty

	// two cycles through read register and output register
	property hsync_latency;
		@(posedge i_ClkB) disable iff (!i_rst_n)
		settle[1] |-> (o_timing_b.hsync == $past(i_timing_b.hsync, 2));
	endproperty

	assert property (locked_sticky) else begin
		$error("o_locked fell after rising");
		fail_count++;
	end
	assert property (blank_pixel_zero) else begin
		$error("o_pixel_b nonzero during blanking");
		fail_count++;
	end
	assert property (hsync_latency) else begin
		$error("o_timing_b.hsync latency is not 2 cycles");
		fail_count++;
	end

endmodule

bind upscaler_top upscaler_assertions u_assertions (
	.i_ClkB(i_ClkB),
	.i_rst_n(i_rst_n),
	.i_timing_b(i_timing_b),
	.o_timing_b(o_timing_b),
	.o_pixel_b(o_pixel_b),
	.o_locked(o_locked)
);

`default_nettype wire

// File: tb_upscaler_top.sv
`default_nettype none

`include "upscaler_config.svh"

module tb_upscaler_top;
	timeunit 1ns;
	timeprecision 1ps;
	import upscaler_pkg::*;

	localparam int PREC = `UPS_DELTA_PRECISION;
	localparam int DEPTH = `UPS_LINE_BUFFER_COUNT;
	localparam int HBLANK = 30;
	localparam int VBLANK_LINES = 4;
	localparam int MAX_TESTS = 8;
	localparam int MAX_W = 16;
	localparam int MAX_H = 8;
	localparam int SETTLE_FRAMES = 4;
	localparam int LOCK_FRAME_LIMIT = 8;
	localparam int START_LIMIT = 5000;

	typedef struct packed {
		logic chk_timing;
		logic chk_pixel;
		video_timing_t timing;
		pixel_t pixel;
	} expect_t;

	logic i_ClkA;
	logic i_ClkB;
	logic i_rst_n;
	video_timing_t i_timing_a;
	pixel_t i_pixel_a;
	video_timing_t i_timing_b;
	video_timing_t o_timing_b;
	pixel_t o_pixel_b;
	logic o_locked;

	int n_tests;
	int src_w [MAX_TESTS];
	int src_h [MAX_TESTS];
	int out_w [MAX_TESTS];
	int out_h [MAX_TESTS];
	pixel_t src_pix [MAX_TESTS][MAX_H][MAX_W];

	int cur_test;
	logic a_run = 1'b0;
	logic pix_check;
	logic a_phase_done = 1'b0;
	int err_count;
	int err_mark;
	int tests_run;
	int tests_failed;

	// output-side model state
	expect_t hist0;
	expect_t hist1;
	logic m_hs_prev;
	logic m_hb_prev;
	logic [DEPTH-1:0] m_vs;
	logic [DEPTH-1:0] m_vb;
	int x_cur;
	int y_cur;
	int y_next;

	upscaler_top i_dut (
		.i_ClkA(i_ClkA),
		.i_ClkB(i_ClkB),
		.i_rst_n(i_rst_n),
		.i_timing_a(i_timing_a),
		.i_pixel_a(i_pixel_a),
		.i_timing_b(i_timing_b),
		.o_timing_b(o_timing_b),
		.o_pixel_b(o_pixel_b),
		.o_locked(o_locked)
	);

	always #5 i_ClkB = ~i_ClkB;

	// domain A lags by 3 ns
	always begin
		if (!a_phase_done) begin
			a_phase_done = 1'b1;
			#3;
		end
		#5 i_ClkA = ~i_ClkA;
	end

	function automatic video_timing_t make_timing(input logic hs, input logic vs,
			input logic hb, input logic vb);
		return '{hsync: hs, vsync: vs, hblank: hb, vblank: vb};
	endfunction

	// fixed-point step, source size over output size
	function automatic longint step_of(input int num, input int den);
		if (den == 0) begin
			return 0;
		end
		return ((longint'(num) << PREC) / den) & ((longint'(1) << (PREC + 1)) - 1);
	endfunction

	function automatic pixel_t expected_pixel(input int t, input int x, input int y);
		int col;
		int row;
		col = int'((longint'(x) * step_of(src_w[t], out_w[t])) >> PREC);
		row = int'((longint'(y) * step_of(src_h[t], out_h[t])) >> PREC);
		if (col >= src_w[t] || row >= src_h[t]) begin
			return '0;
		end
		return src_pix[t][row][col];
	endfunction

	task automatic load_tests();
		int fd;
		int code;
		int w;
		int h;
		int ow;
		int oh;
		logic [23:0] val;
		string hdr;
		n_tests = 0;
		fd = $fopen("upscaler_input.txt", "r");
		if (fd == 0) begin
			$display("could not open upscaler_input.txt");
			err_count++;
		end else begin
			code = $fgets(hdr, fd);
			code = $fgets(hdr, fd);
			while (n_tests < MAX_TESTS && $fscanf(fd, "%d %d %d %d", w, h, ow, oh) == 4) begin
				if (w > MAX_W || h > MAX_H) begin
					$display("test %0d source size %0dx%0d is too large", n_tests, w, h);
					err_count++;
					break;
				end
				src_w[n_tests] = w;
				src_h[n_tests] = h;
				out_w[n_tests] = ow;
				out_h[n_tests] = oh;
				for (int r = 0; r < h; r++) begin
					for (int c = 0; c < w; c++) begin
						code = $fscanf(fd, "%h", val);
						if (code != 1) begin
							$display("test %0d is missing source pixel data", n_tests);
							err_count++;
						end
						src_pix[n_tests][r][c] = val;
					end
				end
				n_tests++;
			end
			$fclose(fd);
			if (n_tests == 0) begin
				$display("no test cases found in upscaler_input.txt");
				err_count++;
			end
		end
	endtask

	task automatic compare_outputs(input expect_t e);
		if (e.chk_timing && o_timing_b !== e.timing) begin
			$display("ERROR o_timing_b expected %h got %h", e.timing, o_timing_b);
			err_count++;
		end
		if (e.chk_pixel && o_pixel_b !== e.pixel) begin
			$display("ERROR o_pixel_b expected %h got %h", e.pixel, o_pixel_b);
			err_count++;
		end
	endtask

	// one output clock: check the result of two cycles ago, then drive
	task automatic b_cycle(input video_timing_t tim);
		expect_t e;
		@(posedge i_ClkB);
		#1;
		compare_outputs(hist1);
		i_timing_b = tim;
		e.chk_timing = 1'b1;
		e.timing = make_timing(tim.hsync, m_vs[DEPTH-1], tim.hblank, m_vb[DEPTH-1]);
		e.chk_pixel = 1'b0;
		e.pixel = '0;
		if (m_hb_prev && !tim.hblank && !m_vb[DEPTH-1]) begin
			y_cur = y_next;
			y_next++;
			x_cur = 0;
		end
		if (tim.hblank || m_vb[DEPTH-1]) begin
			e.chk_pixel = 1'b1;
		end else begin
			e.chk_pixel = pix_check;
			e.pixel = expected_pixel(cur_test, x_cur, y_cur);
			x_cur++;
		end
		// vertical delay steps on each hsync falling edge
		if (m_hs_prev && !tim.hsync) begin
			if (m_vb[DEPTH-1] && !m_vb[DEPTH-2]) begin
				y_next = 0;
			end
			m_vs = {m_vs[DEPTH-2:0], tim.vsync};
			m_vb = {m_vb[DEPTH-2:0], tim.vblank};
		end
		m_hs_prev = tim.hsync;
		m_hb_prev = tim.hblank;
		hist1 = hist0;
		hist0 = e;
	endtask

	task automatic b_frame(input int w, input int h);
		logic vs;
		logic vb;
		for (int ln = 0; ln < h + VBLANK_LINES; ln++) begin
			vb = (ln >= h);
			vs = !(ln == h + 1 || ln == h + 2);
			for (int c = 0; c < w; c++) begin
				b_cycle(make_timing(1'b1, vs, 1'b0, vb));
			end
			for (int c = 0; c < HBLANK; c++) begin
				b_cycle(make_timing(!(c >= 5 && c < 15), vs, 1'b1, vb));
			end
		end
	endtask

	task automatic a_frame();
		int t;
		logic active;
		logic vb;
		t = cur_test;
		for (int ln = 0; ln < src_h[t] + VBLANK_LINES; ln++) begin
			vb = (ln >= src_h[t]);
			for (int c = 0; c < src_w[t] + HBLANK; c++) begin
				@(posedge i_ClkA);
				#1;
				active = (c < src_w[t]);
				i_timing_a = make_timing(!(c >= src_w[t] + 5 && c < src_w[t] + 15),
					!(ln == src_h[t] + 1 || ln == src_h[t] + 2), !active, vb);
				i_pixel_a = (active && !vb) ? src_pix[t][ln][c] : '0;
			end
		end
	endtask

	task automatic report_test(input string name);
		int errs;
		errs = err_count - err_mark;
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("test %0d %s: %s (%0d errors)", tests_run, name, (errs == 0) ? "ok" : "bad", errs);
		err_mark = err_count;
	endtask

	// input stream, free-running once started
	initial begin : input_stream
		int guard;
		guard = 0;
		while (!a_run && guard < START_LIMIT) begin
			@(posedge i_ClkA);
			guard++;
		end
		if (!a_run) begin
			$display("timeout waiting for the input stream to start");
			err_count++;
		end else begin
			forever a_frame();
		end
	end

	initial begin : main_seq
		int seed_val;
		int frames;
		int idle;
		i_ClkA = 1'b0;
		i_ClkB = 1'b0;
		i_rst_n = 1'b0;
		i_timing_a = make_timing(1'b1, 1'b1, 1'b1, 1'b1);
		i_pixel_a = '0;
		i_timing_b = make_timing(1'b1, 1'b1, 1'b1, 1'b1);
		a_run = 1'b0;
		pix_check = 1'b0;
		cur_test = 0;
		err_count = 0;
		err_mark = 0;
		tests_run = 0;
		tests_failed = 0;
		hist0 = '0;
		hist1 = '0;
		m_hs_prev = 1'b1;
		m_hb_prev = 1'b1;
		m_vs = '1;
		m_vb = '0;
		x_cur = 0;
		y_cur = 0;
		y_next = 0;
		seed_val = $urandom(32'ha784);
		load_tests();

		repeat (2) @(posedge i_ClkB);
		#1;
		i_rst_n = 1'b1;

		repeat (4) b_cycle(make_timing(1'b1, 1'b1, 1'b1, 1'b1));
		if (o_locked !== 1'b0) begin
			$display("ERROR o_locked expected %h got %h", 1'b0, o_locked);
			err_count++;
		end
		if (o_pixel_b !== '0) begin
			$display("ERROR o_pixel_b expected %h got %h", 24'h0, o_pixel_b);
			err_count++;
		end
		if (o_timing_b.hsync !== 1'b1 || o_timing_b.vsync !== 1'b1) begin
			$display("ERROR o_timing_b syncs expected %h got %h", 2'b11,
				{o_timing_b.hsync, o_timing_b.vsync});
			err_count++;
		end
		report_test("reset state");

		// input runs a frame, then lock is awaited
		cur_test = 0;
		a_run = 1'b1;
		repeat (2) b_frame(out_w[0], out_h[0]);
		frames = 0;
		while (o_locked !== 1'b1 && frames < LOCK_FRAME_LIMIT) begin
			b_frame(out_w[0], out_h[0]);
			frames++;
		end
		if (o_locked !== 1'b1) begin
			$display("timeout waiting for o_locked to rise");
			err_count++;
		end
		report_test("lock");

		for (int t = 0; t < n_tests; t++) begin
			idle = int'($urandom % 8) + 1;
			repeat (idle) b_cycle(make_timing(1'b1, 1'b1, 1'b1, 1'b1));
			cur_test = t;
			repeat (SETTLE_FRAMES) b_frame(out_w[t], out_h[t]);
			pix_check = 1'b1;
			b_frame(out_w[t], out_h[t]);
			pix_check = 1'b0;
			repeat (2) b_cycle(make_timing(1'b1, 1'b1, 1'b1, 1'b1));
			report_test($sformatf("scale %0dx%0d to %0dx%0d",
				src_w[t], src_h[t], out_w[t], out_h[t]));
		end

		// failures seen by the bound output checker
		if (i_dut.u_assertions.fail_count != 0) begin
			$display("the output checker saw %0d assertion failures",
				i_dut.u_assertions.fail_count);
			err_count += i_dut.u_assertions.fail_count;
		end

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
		if (err_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: upscaler_top.f
+incdir+.
upscaler_pkg.sv
video_input_capture.sv
line_buffer_ram.sv
scale_step_divider.sv
video_output_scaler.sv
upscaler_top.sv
upscaler_assertions.sv
tb_upscaler_top.sv

// File: Makefile
# Verilator build for the upscaler testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP ?= tb_upscaler_top
FILELIST ?= upscaler_top.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(wildcard *.sv) $(wildcard *.svh) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: upscaler_input.txt
# per test: src_width src_height out_width out_height (decimal)
# then src_height rows of src_width pixels, 24-bit rrggbb in hex
4 3 8 6
ff0000 00ff00 0000ff 808080
112233 445566 778899 aabbcc
010203 a0b0c0 deadbe 0f1e2d

4 3 6 5
102030 405060 708090 a0b0c0
c0ffee 00beef facade 123456
654321 abcdef fedcba 0a0b0c

4 3 4 3
202020 404040 606060 808080
a1a2a3 b1b2b3 c1c2c3 d1d2d3
e0e1e2 f0f1f2 090807 7f7f7f
